//--- uart_host_settings.svh
// Bit timing and bank size; UART_CLKS_PER_BIT must be even and at least 4, UART_REG_COUNT at least 2.
`ifndef UART_HOST_SETTINGS_SVH
`define UART_HOST_SETTINGS_SVH

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// centre of a bit, counted from its leading edge
`define UART_HALF_BIT (`UART_CLKS_PER_BIT / 2)

// width of the per-bit cycle counters
`define UART_CNT_W ($clog2(`UART_CLKS_PER_BIT) + 1)

// number of 32-bit registers in the bank
`define UART_REG_COUNT 8

`endif

//--- uart_phy_pkg.sv
// Byte-level types of the 8N1 serial line; no parity bit and a single stop bit are assumed.
`default_nettype none

package uart_phy_pkg;

	// one data byte on the line
	typedef logic [7:0] uart_byte_t;

	// data bits per frame, sent lsb first
	localparam int UART_DATA_BITS = 8;

	// start + data + stop
	localparam int UART_FRAME_BITS = UART_DATA_BITS + 2;

	// bit position inside a frame
	typedef logic [3:0] uart_bit_idx_t;

endpackage

`default_nettype wire

//--- host_proto_pkg.sv
// Hex packet protocol types; only upper-case hex digits are accepted or produced.
`default_nettype none

package host_proto_pkg;

	typedef logic [31:0] host_word_t;
	typedef logic [7:0]  hex_char_t;

	localparam int HEX_DIGITS_PER_WORD = 8;
	// command, address and data
	localparam int FIELDS_PER_PACKET = 3;

	typedef enum logic [31:0] {
		OP_WRITE = 32'd1,
		OP_READ  = 32'd2
	} cmd_op_e;

	typedef enum logic [31:0] {
		ST_OK       = 32'd0,
		ST_BAD_CMD  = 32'd1,
		ST_BAD_ADDR = 32'd2
	} rsp_status_e;

	typedef struct packed {
		host_word_t command;
		host_word_t address;
		host_word_t data;
	} host_cmd_t;

	typedef struct packed {
		rsp_status_e status;
		host_word_t  address;
		host_word_t  data;
	} host_rsp_t;

	// packet start characters L and S
	localparam hex_char_t CHAR_START_CMD = 8'h4C;
	localparam hex_char_t CHAR_START_RSP = 8'h53;
	localparam hex_char_t CHAR_ZERO      = 8'h30;
	localparam hex_char_t CHAR_NINE      = 8'h39;
	localparam hex_char_t CHAR_A         = 8'h41;
	localparam hex_char_t CHAR_F         = 8'h46;

	function automatic logic is_hex_char(hex_char_t c);
		return ((c >= CHAR_ZERO) && (c <= CHAR_NINE)) || ((c >= CHAR_A) && (c <= CHAR_F));
	endfunction

	// only meaningful when is_hex_char holds
	function automatic logic [3:0] hex_char_to_nibble(hex_char_t c);
		hex_char_t v;
		v = (c >= CHAR_A) ? (c - CHAR_A + 8'd10) : (c - CHAR_ZERO);
		return v[3:0];
	endfunction

	function automatic hex_char_t nibble_to_hex_char(logic [3:0] n);
		return (n < 4'd10) ? (CHAR_ZERO + n) : (CHAR_A + n - 8'd10);
	endfunction

endpackage

`default_nettype wire

//--- uart_rx.sv
// 8N1 receiver; a glitch shorter than half a bit is rejected, and a frame with a low stop bit is lost.
`default_nettype none
`include "uart_host_settings.svh"

module uart_rx (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    rx,
	output logic                    rx_valid,
	output uart_phy_pkg::uart_byte_t rx_byte
);
	import uart_phy_pkg::*;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e                state;
	logic [1:0]               rx_sync;
	logic                     rx_prev;
	logic [`UART_CNT_W-1:0]   cyc_cnt;
	uart_bit_idx_t            bit_idx;

	always_ff @(posedge clk) begin
		// single-cycle strobe
		rx_valid <= 1'b0;
		if (rst) begin
			state   <= RX_IDLE;
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			cyc_cnt <= '0;
			bit_idx <= '0;
		end else begin
			// two-flop synchronizer, then one more for edge detect
			rx_sync <= {rx_sync[0], rx};
			rx_prev <= rx_sync[1];
			case (state)
				RX_IDLE: begin
					cyc_cnt <= '0;
					if (rx_prev && !rx_sync[1]) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// recheck at the middle of the start bit
					if (cyc_cnt == `UART_HALF_BIT - 1) begin
						cyc_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (cyc_cnt == `UART_CLKS_PER_BIT - 1) begin
						cyc_cnt <= '0;
						// lsb first
						rx_byte <= {rx_sync[1], rx_byte[7:1]};
						if (bit_idx == UART_DATA_BITS - 1) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (cyc_cnt == `UART_CLKS_PER_BIT - 1) begin
						state    <= RX_IDLE;
						rx_valid <= rx_sync[1];
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- uart_tx.sv
// 8N1 transmitter; it accepts a byte only between frames and always sends exactly one stop bit.
`default_nettype none
`include "uart_host_settings.svh"

module uart_tx (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     tx_valid,
	output logic                     tx_ready,
	input  uart_phy_pkg::uart_byte_t tx_byte,
	output logic                     tx
);
	import uart_phy_pkg::*;

	logic                   busy;
	// remaining data bits plus the stop bit
	logic [8:0]             shreg;
	uart_bit_idx_t          bit_cnt;
	logic [`UART_CNT_W-1:0] cyc_cnt;

	assign tx_ready = !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			tx      <= 1'b1;
			bit_cnt <= '0;
			cyc_cnt <= '0;
		end else if (!busy) begin
			if (tx_valid) begin
				// start bit goes out right after the handshake
				busy    <= 1'b1;
				tx      <= 1'b0;
				shreg   <= {1'b1, tx_byte};
				bit_cnt <= '0;
				cyc_cnt <= '0;
			end
		end else if (cyc_cnt == `UART_CLKS_PER_BIT - 1) begin
			cyc_cnt <= '0;
			if (bit_cnt == UART_FRAME_BITS - 1) begin
				// stop bit done, line stays high
				busy <= 1'b0;
			end else begin
				tx      <= shreg[0];
				shreg   <= {1'b1, shreg[8:1]};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hex_cmd_parser.sv
// L-packet parser; characters that arrive while a command waits for the executor are dropped.
`default_nettype none

module hex_cmd_parser (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rx_valid,
	input  uart_phy_pkg::uart_byte_t  rx_byte,
	output logic                      cmd_valid,
	input  logic                      cmd_ready,
	output host_proto_pkg::host_cmd_t cmd
);
	import host_proto_pkg::*;

	typedef enum logic [1:0] {P_HUNT, P_COLLECT, P_HOLD} parse_state_e;

	parse_state_e                              state;
	logic [$clog2(HEX_DIGITS_PER_WORD)-1:0]    nib_cnt;
	logic [1:0]                                field_idx;
	logic                                      take_digit;
	logic [3:0]                                nibble;

	assign cmd_valid  = (state == P_HOLD);
	assign take_digit = (state == P_COLLECT) && rx_valid && is_hex_char(rx_byte);
	assign nibble     = hex_char_to_nibble(rx_byte);

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= P_HUNT;
			nib_cnt   <= '0;
			field_idx <= '0;
		end else begin
			case (state)
				P_HUNT: begin
					nib_cnt   <= '0;
					field_idx <= '0;
					if (rx_valid && (rx_byte == CHAR_START_CMD)) begin
						state <= P_COLLECT;
					end
				end
				P_COLLECT: begin
					if (take_digit) begin
						nib_cnt <= nib_cnt + 1'b1;
						if (nib_cnt == HEX_DIGITS_PER_WORD - 1) begin
							nib_cnt <= '0;
							if (field_idx == FIELDS_PER_PACKET - 1) begin
								state <= P_HOLD;
							end else begin
								field_idx <= field_idx + 1'b1;
							end
						end
					end else if (rx_valid) begin
						// bad char aborts, an L starts over at once
						nib_cnt   <= '0;
						field_idx <= '0;
						if (rx_byte != CHAR_START_CMD) begin
							state <= P_HUNT;
						end
					end
				end
				P_HOLD: begin
					if (cmd_ready) begin
						state <= P_HUNT;
					end
				end
				default: state <= P_HUNT;
			endcase
		end
	end

	// msb first into the field being filled
	always_ff @(posedge clk) begin
		if (take_digit) begin
			case (field_idx)
				2'd0:    cmd.command <= {cmd.command[27:0], nibble};
				2'd1:    cmd.address <= {cmd.address[27:0], nibble};
				default: cmd.data    <= {cmd.data[27:0], nibble};
			endcase
		end
	end

endmodule

`default_nettype wire

//--- reg_cmd_executor.sv
// Register bank of UART_REG_COUNT words addressed by word index; one command is in flight at a time.
`default_nettype none
`include "uart_host_settings.svh"

module reg_cmd_executor (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      cmd_valid,
	output logic                      cmd_ready,
	input  host_proto_pkg::host_cmd_t cmd,
	output logic                      rsp_valid,
	input  logic                      rsp_ready,
	output host_proto_pkg::host_rsp_t rsp
);
	import host_proto_pkg::*;

	localparam int IDX_W = $clog2(`UART_REG_COUNT);

	host_word_t       regs [`UART_REG_COUNT];
	logic [IDX_W-1:0] idx;
	logic             addr_ok;
	logic             op_ok;

	// no new command until the response has left
	assign cmd_ready = !rsp_valid;
	assign idx       = cmd.address[IDX_W-1:0];
	assign addr_ok   = (cmd.address < `UART_REG_COUNT);
	assign op_ok     = (cmd.command == OP_WRITE) || (cmd.command == OP_READ);

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
			for (int i = 0; i < `UART_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (rsp_valid && rsp_ready) begin
				rsp_valid <= 1'b0;
			end
			if (cmd_valid && cmd_ready) begin
				rsp_valid   <= 1'b1;
				rsp.address <= cmd.address;
				if (!op_ok) begin
					rsp.status <= ST_BAD_CMD;
					rsp.data   <= '0;
				end else if (!addr_ok) begin
					rsp.status <= ST_BAD_ADDR;
					rsp.data   <= '0;
				end else if (cmd.command == OP_WRITE) begin
					// write echoes the stored value
					regs[idx]  <= cmd.data;
					rsp.status <= ST_OK;
					rsp.data   <= cmd.data;
				end else begin
					rsp.status <= ST_OK;
					rsp.data   <= regs[idx];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hex_rsp_formatter.sv
// S-packet formatter; it sends 25 characters per response and takes the next response only when done.
`default_nettype none

module hex_rsp_formatter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rsp_valid,
	output logic                      rsp_ready,
	input  host_proto_pkg::host_rsp_t rsp,
	output logic                      tx_valid,
	input  logic                      tx_ready,
	output uart_phy_pkg::uart_byte_t  tx_byte
);
	import host_proto_pkg::*;

	logic                                   busy;
	// S still to be sent
	logic                                   send_start;
	logic [$clog2(HEX_DIGITS_PER_WORD)-1:0] nib_cnt;
	logic [1:0]                             field_idx;
	host_rsp_t                              rsp_q;
	// field being sent, top nibble goes next
	host_word_t                             word_q;
	logic                                   char_done;

	assign rsp_ready = !busy;
	assign tx_valid  = busy;
	assign tx_byte   = send_start ? CHAR_START_RSP : nibble_to_hex_char(word_q[31:28]);
	assign char_done = busy && tx_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			send_start <= 1'b0;
			nib_cnt    <= '0;
			field_idx  <= '0;
		end else if (!busy) begin
			if (rsp_valid) begin
				busy       <= 1'b1;
				send_start <= 1'b1;
				nib_cnt    <= '0;
				field_idx  <= '0;
			end
		end else if (char_done) begin
			if (send_start) begin
				send_start <= 1'b0;
			end else if (nib_cnt == HEX_DIGITS_PER_WORD - 1) begin
				nib_cnt <= '0;
				if (field_idx == FIELDS_PER_PACKET - 1) begin
					busy <= 1'b0;
				end else begin
					field_idx <= field_idx + 1'b1;
				end
			end else begin
				nib_cnt <= nib_cnt + 1'b1;
			end
		end
	end

	// status, then address, then data
	always_ff @(posedge clk) begin
		if (!busy && rsp_valid) begin
			rsp_q <= rsp;
		end else if (char_done) begin
			if (send_start) begin
				word_q <= rsp_q.status;
			end else if (nib_cnt == HEX_DIGITS_PER_WORD - 1) begin
				word_q <= (field_idx == 2'd0) ? rsp_q.address : rsp_q.data;
			end else begin
				word_q <= {word_q[27:0], 4'h0};
			end
		end
	end

endmodule

`default_nettype wire

//--- uart_host_top.sv
// Serial host port; the host must wait for each reply before it sends the next packet.
`default_nettype none

module uart_host_top (
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx
);
	import uart_phy_pkg::*;
	import host_proto_pkg::*;

	// serial receive side
	logic       rx_valid;
	uart_byte_t rx_byte;

	// parsed command
	logic       cmd_valid;
	logic       cmd_ready;
	host_cmd_t  cmd;

	// executor response
	logic       rsp_valid;
	logic       rsp_ready;
	host_rsp_t  rsp;

	// reply characters
	logic       tx_valid;
	logic       tx_ready;
	uart_byte_t tx_byte;

	uart_rx u_rx (
		.clk      (clk),
		.rst      (rst),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	hex_cmd_parser u_parser (
		.clk       (clk),
		.rst       (rst),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd)
	);

	reg_cmd_executor u_exec (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	hex_rsp_formatter u_fmt (
		.clk       (clk),
		.rst       (rst),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.tx_byte   (tx_byte)
	);

	uart_tx u_tx (
		.clk      (clk),
		.rst      (rst),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_byte  (tx_byte),
		.tx       (tx)
	);

endmodule

`default_nettype wire

//--- tb_uart_host.sv
// Testbench for uart_host_top; needs uart_host_tests.txt in the run directory, with one packet per line.
`default_nettype none
`include "uart_host_settings.svh"

module tb_uart_host;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_phy_pkg::*;
	import host_proto_pkg::*;

	// one character is start + 8 data + stop
	localparam int CHAR_CYCLES     = 10 * `UART_CLKS_PER_BIT;
	localparam int RSP_CHARS       = 1 + 3 * HEX_DIGITS_PER_WORD;
	localparam int REPLY_TIMEOUT   = 40 * CHAR_CYCLES;
	// longest packet the driver may still be sending while we wait
	localparam int SEND_ALLOWANCE  = 64 * CHAR_CYCLES;
	localparam int WATCHDOG_CYCLES = 600000;

	logic clk;
	logic rst;
	logic rx;
	logic tx;

	// high while the driver is still shifting out a packet
	logic       sending;
	uart_byte_t reply_chars [RSP_CHARS];
	int         mismatch_count;
	int         failure_count;
	int         test_count;

	uart_host_top DUT (
		.clk (clk),
		.rst (rst),
		.rx  (rx),
		.tx  (tx)
	);

	always #50 clk = ~clk;

	task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_status(input string name, input rsp_status_e got, input rsp_status_e exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %0d (%s) expected %0d (%s)",
				$time, name, got, got.name(), exp, exp.name());
			mismatch_count++;
		end
	endtask

	task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	// bit 4 set when c is 0-9 or upper-case A-F
	function automatic logic [4:0] decode_hex_char(input uart_byte_t c);
		if (c >= 8'h30 && c <= 8'h39) begin
			return {1'b1, c[3:0]};
		end else if (c >= 8'h41 && c <= 8'h46) begin
			return {1'b1, c[3:0] + 4'd9};
		end
		return 5'b0;
	endfunction

	// one bit held for a full bit time, changed on a rising edge
	task automatic drive_bit(input logic b);
		@(posedge clk);
		rx <= b;
		repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
	endtask

	task automatic send_string(input string s);
		int         i;
		int         b;
		uart_byte_t ch;
		sending = 1'b1;
		for (i = 0; i < s.len(); i++) begin
			ch = s[i];
			drive_bit(1'b0);
			// lsb first
			for (b = 0; b < 8; b++) begin
				drive_bit(ch[b]);
			end
			drive_bit(1'b1);
		end
		sending = 1'b0;
	endtask

	// idle cycles only count once the packet is out
	task automatic wait_line_low(input int idle_limit, output logic found);
		int idle_cnt;
		int total_cnt;
		idle_cnt  = 0;
		total_cnt = 0;
		found     = 1'b0;
		while (!found && idle_cnt < idle_limit && total_cnt < idle_limit + SEND_ALLOWANCE) begin
			@(negedge clk);
			total_cnt++;
			if (tx === 1'b0) begin
				found = 1'b1;
			end else if (!sending) begin
				idle_cnt++;
			end
		end
	endtask

	// entered half a cycle after the start edge
	task automatic receive_char(output uart_byte_t c, output logic frame_ok);
		int b;
		frame_ok = 1'b1;
		repeat (`UART_HALF_BIT - 1) @(negedge clk);
		if (tx !== 1'b0) begin
			frame_ok = 1'b0;
		end
		for (b = 0; b < 8; b++) begin
			repeat (`UART_CLKS_PER_BIT) @(negedge clk);
			c[b] = tx;
		end
		// stop bit centre
		repeat (`UART_CLKS_PER_BIT) @(negedge clk);
		if (tx !== 1'b1) begin
			frame_ok = 1'b0;
		end
	endtask

	task automatic decode_field(input int first, output host_word_t value);
		logic [4:0] digit;
		int         k;
		value = '0;
		for (k = 0; k < HEX_DIGITS_PER_WORD; k++) begin
			digit = decode_hex_char(reply_chars[first + k]);
			if (!digit[4]) begin
				$display("[%0t] reply character %0d (%h) is not an upper-case hex digit",
					$time, first + k, reply_chars[first + k]);
				failure_count++;
			end
			value = {value[27:0], digit[3:0]};
		end
	endtask

	task automatic collect_reply(input logic reply_expected, input rsp_status_e exp_status,
			input host_word_t exp_addr, input host_word_t exp_data);
		logic       found;
		logic       frame_ok;
		logic       complete;
		host_word_t fields [3];
		int         i;
		complete = 1'b1;
		wait_line_low(REPLY_TIMEOUT, found);
		if (!found) begin
			complete = 1'b0;
			if (reply_expected) begin
				$display("[%0t] timeout: no reply within 40 character times", $time);
				failure_count++;
			end
		end else if (!reply_expected) begin
			$display("[%0t] a reply came back for a packet that should be dropped", $time);
			failure_count++;
		end
		// unexpected replies are drained too, so the next test starts clean
		for (i = 0; complete && i < RSP_CHARS; i++) begin
			if (i > 0) begin
				wait_line_low(2 * CHAR_CYCLES, found);
			end
			if (!found) begin
				$display("[%0t] timeout: reply stopped after %0d characters", $time, i);
				failure_count++;
				complete = 1'b0;
			end else begin
				receive_char(reply_chars[i], frame_ok);
				if (!frame_ok) begin
					$display("[%0t] reply character %0d has a bad start or stop bit", $time, i);
					failure_count++;
				end
			end
		end
		if (complete && reply_expected) begin
			check_byte("reply start", reply_chars[0], CHAR_START_RSP);
			for (i = 0; i < 3; i++) begin
				decode_field(1 + i * HEX_DIGITS_PER_WORD, fields[i]);
			end
			check_status("status", rsp_status_e'(fields[0]), exp_status);
			check_word("address", fields[1], exp_addr);
			check_word("data", fields[2], exp_data);
		end
	endtask

	// line must stay idle for two character times
	task automatic check_idle_after_reset();
		int  c;
		logic seen_low;
		seen_low = 1'b0;
		for (c = 0; c < 2 * CHAR_CYCLES; c++) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				seen_low = 1'b1;
			end
		end
		if (seen_low) begin
			$display("[%0t] tx left the idle level after reset", $time);
			failure_count++;
		end
	endtask

	initial begin : run_watchdog
		int c;
		for (c = 0; c < WATCHDOG_CYCLES; c++) begin
			@(posedge clk);
		end
		$display("timeout: the run went past %0d clock cycles", WATCHDOG_CYCLES);
		$display("errors: %0d mismatches, %0d other failures, %0d tests run",
			mismatch_count, failure_count, test_count);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : run_tests
		int         fd;
		int         n;
		int         reply_flag;
		string      line;
		string      chars;
		host_word_t st_val;
		host_word_t addr_val;
		host_word_t data_val;
		clk            = 1'b0;
		rst            = 1'b1;
		rx             = 1'b1;
		sending        = 1'b0;
		mismatch_count = 0;
		failure_count  = 0;
		test_count     = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		check_idle_after_reset();

		fd = $fopen("uart_host_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open uart_host_tests.txt");
			failure_count++;
		end
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			n    = $fgets(line, fd);
			// skip blank and comment lines
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%s %d %h %h %h", chars, reply_flag, st_val, addr_val, data_val);
				if (n != 5) begin
					$display("a test line could not be read: %s", line);
					failure_count++;
				end else begin
					test_count++;
					fork
						send_string(chars);
						collect_reply(reply_flag != 0, rsp_status_e'(st_val), addr_val, data_val);
					join
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (test_count == 0) begin
			$display("no tests were run");
			failure_count++;
		end

		$display("errors: %0d mismatches, %0d other failures, %0d tests run",
			mismatch_count, failure_count, test_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- uart_host_tests.txt
# columns: chars_sent reply_expected status address data (last three in hex)
# reply_expected 0 means the port must stay silent and the last three columns are unused
L000000020000000300000000 1 0 00000003 00000000
L00000001000000051234ABCD 1 0 00000005 1234ABCD
L000000020000000500000000 1 0 00000005 1234ABCD
L0000000100000002CAFE0042 1 0 00000002 CAFE0042
L000000020000000500000000 1 0 00000005 1234ABCD
L000000020000000200000000 1 0 00000002 CAFE0042
L00000007000000050BADF00D 1 1 00000005 00000000
L000000020000000500000000 1 0 00000005 1234ABCD
L0000000100000008DEADBEEF 1 2 00000008 00000000
L00000002FFFFFFFF00000000 1 2 FFFFFFFF 00000000
L0000000100000005abcd0000 0 0 00000000 00000000
L000000020000000500000000 1 0 00000005 1234ABCD
L00000001000000G512345678 0 0 00000000 00000000
L0000L00000001000000060089ABEF 1 0 00000006 0089ABEF
L0000000100000007FEDCBA98 1 0 00000007 FEDCBA98
L000000020000000700000000 1 0 00000007 FEDCBA98
L000000010000000176543210 1 0 00000001 76543210
L0000000189ABCDEF01234567 1 2 89ABCDEF 00000000

//--- uart_host.f
+incdir+.
uart_phy_pkg.sv
host_proto_pkg.sv
uart_rx.sv
uart_tx.sv
hex_cmd_parser.sv
reg_cmd_executor.sv
hex_rsp_formatter.sv
uart_host_top.sv
tb_uart_host.sv

//--- Bender.yml
package:
  name: uart_host

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_phy_pkg.sv
      - host_proto_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - hex_cmd_parser.sv
      - reg_cmd_executor.sv
      - hex_rsp_formatter.sv
      - uart_host_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_host.sv
